// File: list.f
+incdir+verification
src/soc_map_pkg.sv
src/periph_pkg.sv
src/bus_decoder.sv
src/block_ram.sv
src/led_ctrl.sv
src/uart_regs.sv
src/uart_tx.sv
src/machine.sv
verification/tb_machine.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tb_machine -o sim_machine \
   && ./obj_dir/sim_machine > sim.log 2>&1 \
   || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1

// File: src/block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram (
   input  wire                              clk,
   input  wire                              rst_n,
   input  wire                              rd,
   input  wire                              wr,
   input  wire  [soc_map_pkg::RAM_AW-1:0]   addr,
   input  wire  [soc_map_pkg::DATA_W-1:0]   wr_data,
   input  wire  [soc_map_pkg::MASK_W-1:0]   wr_mask,
   output logic [soc_map_pkg::DATA_W-1:0]   rd_data,
   output logic                             rd_valid
);
   import soc_map_pkg::*;

   logic [DATA_W-1:0] mem [RAM_WORDS];

   // each mask bit enables one byte lane of the word
   always_ff @(posedge clk) begin
      if (wr) begin
         for (int lane = 0; lane < MASK_W; lane++) begin
            if (wr_mask[lane]) begin
               mem[addr][8*lane +: 8] <= wr_data[8*lane +: 8];
            end
         end
      end
      if (rd) begin
         rd_data <= mem[addr];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd;
      end
   end

endmodule

`default_nettype wire

// File: src/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire  [soc_map_pkg::ADDR_W-1:0]     addr,
   input  wire                                rd_en,
   input  wire                                wr_en,
   input  wire  [soc_map_pkg::DATA_W-1:0]     wr_data,
   input  wire  [soc_map_pkg::MASK_W-1:0]     wr_mask,
   output logic [soc_map_pkg::DATA_W-1:0]     rd_data,
   output logic                               rd_valid,
   output logic                               ram_rd,
   output logic                               ram_wr,
   output logic [soc_map_pkg::RAM_AW-1:0]     ram_addr,
   output logic [soc_map_pkg::DATA_W-1:0]     ram_wr_data,
   output logic [soc_map_pkg::MASK_W-1:0]     ram_wr_mask,
   input  wire  [soc_map_pkg::DATA_W-1:0]     ram_rd_data,
   input  wire                                ram_rd_valid,
   output logic                               led_rd,
   output logic                               led_wr,
   output logic [periph_pkg::REG_OFS_W-1:0]   led_ofs,
   output logic [periph_pkg::REG_WR_W-1:0]    led_wr_data,
   input  wire  [soc_map_pkg::DATA_W-1:0]     led_rd_data,
   input  wire                                led_rd_valid,
   output logic                               uart_rd,
   output logic                               uart_wr,
   output logic [periph_pkg::REG_OFS_W-1:0]   uart_ofs,
   output logic [periph_pkg::REG_WR_W-1:0]    uart_wr_data,
   input  wire  [soc_map_pkg::DATA_W-1:0]     uart_rd_data,
   input  wire                                uart_rd_valid
);
   import soc_map_pkg::*;
   import periph_pkg::*;

   region_t region;
   region_t rd_region_q;
   logic    none_valid_q;

   always_comb begin
      if (addr[ADDR_W-1 -: 2] == RAM_TAG)
         region = REGION_RAM;
      else if (addr[ADDR_W-1 -: 4] == LED_TAG)
         region = REGION_LED;
      else if (addr[ADDR_W-1 -: 4] == UART_TAG)
         region = REGION_UART;
      else
         region = REGION_NONE;
   end

   assign ram_rd  = rd_en && (region == REGION_RAM);
   assign ram_wr  = wr_en && (region == REGION_RAM);
   assign led_rd  = rd_en && (region == REGION_LED);
   assign led_wr  = wr_en && (region == REGION_LED);
   assign uart_rd = rd_en && (region == REGION_UART);
   assign uart_wr = wr_en && (region == REGION_UART);

   assign ram_addr     = addr[WORD_LSB +: RAM_AW];
   assign ram_wr_data  = wr_data;
   assign ram_wr_mask  = wr_mask;
   assign led_ofs      = addr[WORD_LSB +: REG_OFS_W];
   assign led_wr_data  = wr_data[REG_WR_W-1:0];
   assign uart_ofs     = addr[WORD_LSB +: REG_OFS_W];
   assign uart_wr_data = wr_data[REG_WR_W-1:0];

   // the region of the read in flight picks the answer one cycle later
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_region_q  <= REGION_NONE;
         none_valid_q <= 1'b0;
      end else begin
         rd_region_q  <= rd_en ? region : REGION_NONE;
         none_valid_q <= rd_en && (region == REGION_NONE);
      end
   end

   always_comb begin
      case (rd_region_q)
         REGION_RAM: begin
            rd_data  = ram_rd_data;
            rd_valid = ram_rd_valid;
         end
         REGION_LED: begin
            rd_data  = led_rd_data;
            rd_valid = led_rd_valid;
         end
         REGION_UART: begin
            rd_data  = uart_rd_data;
            rd_valid = uart_rd_valid;
         end
         default: begin
            // unmapped reads are answered here with zero
            rd_data  = '0;
            rd_valid = none_valid_q;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/led_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module led_ctrl (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               rd,
   input  wire                               wr,
   input  wire  [periph_pkg::REG_OFS_W-1:0]  ofs,
   input  wire  [periph_pkg::REG_WR_W-1:0]   wr_data,
   output logic [soc_map_pkg::DATA_W-1:0]    rd_data,
   output logic                              rd_valid,
   output logic                              led1,
   output logic                              led2,
   output logic                              led3
);
   import soc_map_pkg::*;
   import periph_pkg::*;

   led_reg_t             reg_sel;
   logic                 period_wr;
   logic [LED_COUNT-1:0] led_out_q;
   logic [LED_COUNT-1:0] blink_mask_q;
   logic [LED_COUNT-1:0] pins;
   logic [BLINK_W-1:0]   period_q;
   logic [BLINK_W-1:0]   count_q;
   logic                 phase_q;

   assign reg_sel   = led_reg_t'(ofs);
   assign period_wr = wr && (reg_sel == LED_BLINK_PERIOD);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         led_out_q    <= '0;
         blink_mask_q <= '0;
         period_q     <= BLINK_RESET;
         count_q      <= '0;
         phase_q      <= 1'b0;
         rd_valid     <= 1'b0;
      end else begin
         if (wr && (reg_sel == LED_OUT))
            led_out_q <= wr_data[LED_COUNT-1:0];
         if (wr && (reg_sel == LED_BLINK_MASK))
            blink_mask_q <= wr_data[LED_COUNT-1:0];
         // a new period starts counting from zero
         if (period_wr) begin
            period_q <= BLINK_W'(wr_data);
            count_q  <= '0;
         end else if (count_q >= period_q) begin
            count_q <= '0;
            phase_q <= ~phase_q;
         end else begin
            count_q <= count_q + BLINK_W'(1);
         end
         rd_valid <= rd;
      end
   end

   always_ff @(posedge clk) begin
      if (rd) begin
         case (reg_sel)
            LED_OUT:          rd_data <= DATA_W'(led_out_q);
            LED_BLINK_MASK:   rd_data <= DATA_W'(blink_mask_q);
            LED_BLINK_PERIOD: rd_data <= DATA_W'(period_q);
            default:          rd_data <= '0;
         endcase
      end
   end

   assign pins = led_out_q ^ (blink_mask_q & {LED_COUNT{phase_q}});
   assign led1 = pins[0];
   assign led2 = pins[1];
   assign led3 = pins[2];

endmodule

`default_nettype wire

// File: src/machine.sv
`timescale 1ns/1ps
`default_nettype none

module machine (
   input  wire                              clk,
   input  wire                              rst_n,
   input  wire  [soc_map_pkg::ADDR_W-1:0]   addr,
   input  wire                              rd_en,
   input  wire                              wr_en,
   input  wire  [soc_map_pkg::DATA_W-1:0]   wr_data,
   input  wire  [soc_map_pkg::MASK_W-1:0]   wr_mask,
   output wire  [soc_map_pkg::DATA_W-1:0]   rd_data,
   output wire                              rd_valid,
   output wire                              led1,
   output wire                              led2,
   output wire                              led3,
   output wire                              uart_tx
);
   import soc_map_pkg::*;
   import periph_pkg::*;

   logic                 ram_rd;
   logic                 ram_wr;
   logic [RAM_AW-1:0]    ram_addr;
   logic [DATA_W-1:0]    ram_wr_data;
   logic [MASK_W-1:0]    ram_wr_mask;
   logic [DATA_W-1:0]    ram_rd_data;
   logic                 ram_rd_valid;

   logic                 led_rd;
   logic                 led_wr;
   logic [REG_OFS_W-1:0] led_ofs;
   logic [REG_WR_W-1:0]  led_wr_data;
   logic [DATA_W-1:0]    led_rd_data;
   logic                 led_rd_valid;

   logic                 uart_rd;
   logic                 uart_wr;
   logic [REG_OFS_W-1:0] uart_ofs;
   logic [REG_WR_W-1:0]  uart_wr_data;
   logic [DATA_W-1:0]    uart_rd_data;
   logic                 uart_rd_valid;

   // between the UART register block and the shifter
   logic                 tx_busy;
   logic                 tx_start;
   logic [REG_WR_W-1:0]  tx_byte;
   logic [DIV_W-1:0]     tx_divisor;

   bus_decoder dec0 (
      .clk(clk), .rst_n(rst_n),
      .addr(addr), .rd_en(rd_en), .wr_en(wr_en),
      .wr_data(wr_data), .wr_mask(wr_mask),
      .rd_data(rd_data), .rd_valid(rd_valid),
      .ram_rd(ram_rd), .ram_wr(ram_wr), .ram_addr(ram_addr),
      .ram_wr_data(ram_wr_data), .ram_wr_mask(ram_wr_mask),
      .ram_rd_data(ram_rd_data), .ram_rd_valid(ram_rd_valid),
      .led_rd(led_rd), .led_wr(led_wr), .led_ofs(led_ofs),
      .led_wr_data(led_wr_data),
      .led_rd_data(led_rd_data), .led_rd_valid(led_rd_valid),
      .uart_rd(uart_rd), .uart_wr(uart_wr), .uart_ofs(uart_ofs),
      .uart_wr_data(uart_wr_data),
      .uart_rd_data(uart_rd_data), .uart_rd_valid(uart_rd_valid)
   );

   block_ram ram0 (
      .clk(clk), .rst_n(rst_n),
      .rd(ram_rd), .wr(ram_wr), .addr(ram_addr),
      .wr_data(ram_wr_data), .wr_mask(ram_wr_mask),
      .rd_data(ram_rd_data), .rd_valid(ram_rd_valid)
   );

   led_ctrl led0 (
      .clk(clk), .rst_n(rst_n),
      .rd(led_rd), .wr(led_wr), .ofs(led_ofs), .wr_data(led_wr_data),
      .rd_data(led_rd_data), .rd_valid(led_rd_valid),
      .led1(led1), .led2(led2), .led3(led3)
   );

   uart_regs uregs0 (
      .clk(clk), .rst_n(rst_n),
      .rd(uart_rd), .wr(uart_wr), .ofs(uart_ofs), .wr_data(uart_wr_data),
      .rd_data(uart_rd_data), .rd_valid(uart_rd_valid),
      .busy(tx_busy), .tx_start(tx_start), .tx_byte(tx_byte),
      .divisor(tx_divisor)
   );

   uart_tx utx0 (
      .clk(clk), .rst_n(rst_n),
      .tx_start(tx_start), .tx_byte(tx_byte), .divisor(tx_divisor),
      .busy(tx_busy), .tx(uart_tx)
   );

endmodule

`default_nettype wire

// File: src/periph_pkg.sv
`default_nettype none

package periph_pkg;

   localparam int REG_OFS_W = 2;
   // peripherals take only the low byte of a write
   localparam int REG_WR_W  = 8;

   typedef enum logic [REG_OFS_W-1:0] {
      LED_OUT          = 2'd0,
      LED_BLINK_MASK   = 2'd1,
      LED_BLINK_PERIOD = 2'd2
   } led_reg_t;

   typedef enum logic [REG_OFS_W-1:0] {
      UART_DATA    = 2'd0,
      UART_STATUS  = 2'd1,
      UART_DIVISOR = 2'd2
   } uart_reg_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } uart_state_t;

   localparam int DIV_W = 16;
   localparam logic [DIV_W-1:0] UART_DIV_RESET = 16'd16;

   localparam int LED_COUNT = 3;
   localparam int BLINK_W   = 24;
   localparam logic [BLINK_W-1:0] BLINK_RESET = 24'd1000;

endpackage

`default_nettype wire

// File: src/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

   // master bus
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int MASK_W = 4;

   // scratch RAM
   localparam int RAM_WORDS = 1024;
   localparam int RAM_AW    = 10;

   // word index and register offset both start above the byte lane bits
   localparam int WORD_LSB = 2;

   // upper address bits that pick a target
   localparam logic [1:0] RAM_TAG  = 2'b00;
   localparam logic [3:0] LED_TAG  = 4'b0100;
   localparam logic [3:0] UART_TAG = 4'b0101;

   typedef enum logic [1:0] {
      REGION_NONE,
      REGION_RAM,
      REGION_LED,
      REGION_UART
   } region_t;

endpackage

`default_nettype wire

// File: src/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               rd,
   input  wire                               wr,
   input  wire  [periph_pkg::REG_OFS_W-1:0]  ofs,
   input  wire  [periph_pkg::REG_WR_W-1:0]   wr_data,
   output logic [soc_map_pkg::DATA_W-1:0]    rd_data,
   output logic                              rd_valid,
   input  wire                               busy,
   output logic                              tx_start,
   output logic [periph_pkg::REG_WR_W-1:0]   tx_byte,
   output logic [periph_pkg::DIV_W-1:0]      divisor
);
   import soc_map_pkg::*;
   import periph_pkg::*;

   uart_reg_t reg_sel;
   logic      tx_active;
   logic      data_wr;
   logic      status_rd;
   logic      overrun_q;

   assign reg_sel = uart_reg_t'(ofs);

   // a start already issued counts as busy until the shifter raises busy
   assign tx_active = busy | tx_start;
   assign data_wr   = wr && (reg_sel == UART_DATA);
   assign status_rd = rd && (reg_sel == UART_STATUS);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_start  <= 1'b0;
         overrun_q <= 1'b0;
         divisor   <= UART_DIV_RESET;
         rd_valid  <= 1'b0;
      end else begin
         tx_start <= data_wr && !tx_active;
         // a byte written during a frame is lost and flagged
         if (data_wr && tx_active)
            overrun_q <= 1'b1;
         else if (status_rd)
            overrun_q <= 1'b0;
         if (wr && (reg_sel == UART_DIVISOR))
            divisor <= DIV_W'(wr_data);
         rd_valid <= rd;
      end
   end

   always_ff @(posedge clk) begin
      if (data_wr && !tx_active) begin
         tx_byte <= wr_data;
      end
      if (rd) begin
         case (reg_sel)
            UART_DATA:    rd_data <= DATA_W'(tx_byte);
            UART_STATUS:  rd_data <= DATA_W'({overrun_q, tx_active});
            UART_DIVISOR: rd_data <= DATA_W'(divisor);
            default:      rd_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire                              clk,
   input  wire                              rst_n,
   input  wire                              tx_start,
   input  wire  [periph_pkg::REG_WR_W-1:0]  tx_byte,
   input  wire  [periph_pkg::DIV_W-1:0]     divisor,
   output logic                             busy,
   output logic                             tx
);
   import periph_pkg::*;

   localparam int BIT_CNT_W = $clog2(REG_WR_W);

   uart_state_t          state_q;
   logic [DIV_W-1:0]     div_q;
   logic [DIV_W-1:0]     timer_q;
   logic [BIT_CNT_W-1:0] bit_cnt_q;
   logic [REG_WR_W-1:0]  shift_q;
   logic                 bit_done;

   assign bit_done = (timer_q == div_q - DIV_W'(1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= TX_IDLE;
         timer_q   <= '0;
         bit_cnt_q <= '0;
      end else begin
         case (state_q)
            TX_IDLE: begin
               timer_q <= '0;
               if (tx_start)
                  state_q <= TX_START;
            end
            TX_START: begin
               if (bit_done) begin
                  timer_q   <= '0;
                  bit_cnt_q <= '0;
                  state_q   <= TX_DATA;
               end else begin
                  timer_q <= timer_q + DIV_W'(1);
               end
            end
            TX_DATA: begin
               if (bit_done) begin
                  timer_q <= '0;
                  if (bit_cnt_q == BIT_CNT_W'(REG_WR_W - 1))
                     state_q <= TX_STOP;
                  else
                     bit_cnt_q <= bit_cnt_q + BIT_CNT_W'(1);
               end else begin
                  timer_q <= timer_q + DIV_W'(1);
               end
            end
            default: begin
               if (bit_done)
                  state_q <= TX_IDLE;
               else
                  timer_q <= timer_q + DIV_W'(1);
            end
         endcase
      end
   end

   // the divisor is held for the whole frame
   always_ff @(posedge clk) begin
      if ((state_q == TX_IDLE) && tx_start) begin
         shift_q <= tx_byte;
         div_q   <= divisor;
      end else if ((state_q == TX_DATA) && bit_done) begin
         shift_q <= shift_q >> 1;
      end
   end

   always_comb begin
      case (state_q)
         TX_START: tx = 1'b0;
         TX_DATA:  tx = shift_q[0];
         default:  tx = 1'b1;
      endcase
   end

   assign busy = (state_q != TX_IDLE);

endmodule

`default_nettype wire

// File: verification/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

   localparam int VALID_WAIT = 4;
   localparam int START_WAIT = 80;

   // all tasks start and end 1 ns after a rising edge
   task automatic bus_write(input logic [15:0] a, input logic [31:0] data,
                            input logic [3:0] mask);
      addr    = a;
      wr_data = data;
      wr_mask = mask;
      wr_en   = 1'b1;
      @(posedge clk);
      #1;
      wr_en = 1'b0;
   endtask

   task automatic bus_read(input logic [15:0] a, output logic [31:0] data);
      int waited;
      addr  = a;
      rd_en = 1'b1;
      @(posedge clk);
      #1;
      rd_en  = 1'b0;
      waited = 0;
      while (rd_valid !== 1'b1 && waited < VALID_WAIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (rd_valid !== 1'b1) begin
         value_errors++;
         $display("no rd_valid within %0d cycles after the read of address %h", VALID_WAIT, a);
      end
      data = rd_data;
   endtask

   task automatic receive_uart_byte(input int bit_cycles, output logic [7:0] data,
                                    output logic framed);
      int   waited;
      logic start_low;
      data   = 8'h00;
      framed = 1'b0;
      waited = 0;
      while (uart_tx === 1'b1 && waited < START_WAIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (uart_tx !== 1'b0) begin
         $display("no start bit seen on uart_tx within %0d cycles", START_WAIT);
      end else begin
         // step to the middle of the start bit, then one bit time per sample
         repeat (bit_cycles / 2) @(posedge clk);
         #1;
         start_low = (uart_tx === 1'b0);
         for (int i = 0; i < 8; i++) begin
            repeat (bit_cycles) @(posedge clk);
            #1;
            data[i] = uart_tx;
         end
         repeat (bit_cycles) @(posedge clk);
         #1;
         framed = start_low && (uart_tx === 1'b1);
      end
   endtask

`endif

// File: verification/tb_machine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_machine;

   // the tests take about 200 cycles and the UART frames take most of them
   localparam int MAX_CYCLES = 3000;
   localparam int RAM_TESTS  = 8;
   localparam int SEQ_READS  = 6;
   localparam int UART_DIV   = 4;

   localparam logic [15:0] UNMAPPED_ADDR    = 16'h6000;
   localparam logic [15:0] LED_OUT_ADDR     = 16'h4000;
   localparam logic [15:0] LED_MASK_ADDR    = 16'h4004;
   localparam logic [15:0] LED_PERIOD_ADDR  = 16'h4008;
   localparam logic [15:0] UART_DATA_ADDR   = 16'h5000;
   localparam logic [15:0] UART_STATUS_ADDR = 16'h5004;
   localparam logic [15:0] UART_DIV_ADDR    = 16'h5008;

   logic        clk;
   logic        rst_n;
   logic [15:0] addr;
   logic        rd_en;
   logic        wr_en;
   logic [31:0] wr_data;
   logic [3:0]  wr_mask;
   wire  [31:0] rd_data;
   wire         rd_valid;
   wire         led1;
   wire         led2;
   wire         led3;
   wire         uart_tx;

   int     checks       = 0;
   int     value_errors = 0;
   int     valid_errors = 0;
   int     idle_errors  = 0;
   int     timed_out    = 0;
   int     cycle_count  = 0;
   integer seed         = 57;

   logic [31:0] ram_model [1024];
   logic [9:0]  ram_idx [RAM_TESTS];

   machine dut0 (
      .clk(clk), .rst_n(rst_n),
      .addr(addr), .rd_en(rd_en), .wr_en(wr_en),
      .wr_data(wr_data), .wr_mask(wr_mask),
      .rd_data(rd_data), .rd_valid(rd_valid),
      .led1(led1), .led2(led2), .led3(led3),
      .uart_tx(uart_tx)
   );

   always #50 clk = ~clk;

   `include "tb_bus_tasks.svh"

   // every read is answered exactly one cycle later
   assert property (@(posedge clk) disable iff (!rst_n) rd_valid == $past(rd_en))
      else begin
         valid_errors++;
         $display("FAILED t=%0t: rd_valid does not follow rd_en by one cycle", $time);
      end

   assert property (@(posedge clk) disable iff (!rst_n)
                    (!dut0.tx_busy && !$past(dut0.tx_busy)) |-> uart_tx)
      else begin
         idle_errors++;
         $display("FAILED t=%0t: uart_tx is low while the transmitter is idle", $time);
      end

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      checks++;
      assert (got === exp)
         else begin
            value_errors++;
            $display("FAILED t=%0t: %s, got %h, expected %h", $time, what, got, exp);
         end
   endtask

   function automatic logic [15:0] ram_byte_addr(input logic [9:0] idx);
      return {4'b0000, idx, 2'b00};
   endfunction

   // only the byte lanes whose mask bit is set take the new data
   function automatic logic [31:0] merge_masked(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] mask);
      logic [31:0] merged;
      merged = old;
      for (int lane = 0; lane < 4; lane++) begin
         if (mask[lane])
            merged[8*lane +: 8] = data[8*lane +: 8];
      end
      return merged;
   endfunction

   task automatic wait_uart_idle();
      logic [31:0] status;
      int          tries;
      tries  = 0;
      status = 32'd1;
      while (status[0] && tries < 40) begin
         bus_read(UART_STATUS_ADDR, status);
         tries++;
      end
      if (status[0]) begin
         value_errors++;
         $display("the UART still reports busy after %0d status reads", tries);
      end
   endtask

   task automatic report_and_finish();
      int failures;
      failures = value_errors + valid_errors + idle_errors + timed_out;
      $display("checks %0d, value errors %0d, valid errors %0d, idle errors %0d, timeouts %0d",
               checks, value_errors, valid_errors, idle_errors, timed_out);
      if (failures == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         timed_out = 1;
         $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
         report_and_finish();
      end
   end

   initial begin
      logic [31:0] data;
      logic [31:0] word;
      logic [31:0] status_a;
      logic [31:0] status_b;
      logic [3:0]  mask;
      logic [7:0]  led_val;
      logic [7:0]  byte_a;
      logic [7:0]  byte_b;
      logic [7:0]  byte_c;
      logic [7:0]  rx_byte;
      logic        framed;
      logic        led1_prev;
      logic [15:0] seq_addr [SEQ_READS];
      logic [31:0] seq_exp [SEQ_READS];
      int          toggles;
      int          drift;
      int          low_count;

      clk     = 1'b0;
      rst_n   = 1'b0;
      addr    = '0;
      rd_en   = 1'b0;
      wr_en   = 1'b0;
      wr_data = '0;
      wr_mask = '0;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      check_value(32'(rd_valid), 32'd0, "rd_valid after reset");
      check_value(32'(uart_tx), 32'd1, "uart_tx after reset");
      check_value(32'({led3, led2, led1}), 32'd0, "leds after reset");
      bus_read(UNMAPPED_ADDR, data);
      check_value(data, 32'd0, "unmapped read");

      // each word gets a full write first so that its masked update is fully known
      for (int i = 0; i < RAM_TESTS; i++) begin
         ram_idx[i] = 10'($random(seed));
         word = $random(seed);
         bus_write(ram_byte_addr(ram_idx[i]), word, 4'hF);
         ram_model[ram_idx[i]] = word;
      end
      for (int i = 0; i < RAM_TESTS; i++) begin
         word = $random(seed);
         mask = 4'($random(seed));
         bus_write(ram_byte_addr(ram_idx[i]), word, mask);
         ram_model[ram_idx[i]] = merge_masked(ram_model[ram_idx[i]], word, mask);
      end
      for (int i = 0; i < RAM_TESTS; i++) begin
         bus_read(ram_byte_addr(ram_idx[i]), data);
         check_value(data, ram_model[ram_idx[i]], "ram read back");
      end

      led_val = 8'($random(seed));
      bus_write(LED_OUT_ADDR, 32'(led_val), 4'hF);
      for (int i = 0; i < SEQ_READS; i++) begin
         if (i % 2 == 0) begin
            seq_addr[i] = ram_byte_addr(ram_idx[i / 2]);
            seq_exp[i]  = ram_model[ram_idx[i / 2]];
         end else begin
            seq_addr[i] = LED_OUT_ADDR;
            seq_exp[i]  = {29'd0, led_val[2:0]};
         end
      end
      // a new read goes out while the previous result comes back
      for (int i = 0; i <= SEQ_READS; i++) begin
         if (i < SEQ_READS) begin
            addr  = seq_addr[i];
            rd_en = 1'b1;
         end else begin
            rd_en = 1'b0;
         end
         if (i > 0) begin
            check_value(32'(rd_valid), 32'd1, "rd_valid of a back-to-back read");
            check_value(rd_data, seq_exp[i-1], "back-to-back read data");
         end
         @(posedge clk);
         #1;
      end

      bus_write(LED_OUT_ADDR, 32'h5, 4'hF);
      check_value(32'({led3, led2, led1}), 32'h5, "leds follow LED_OUT");
      bus_write(LED_MASK_ADDR, 32'h1, 4'hF);
      bus_write(LED_PERIOD_ADDR, 32'd3, 4'hF);
      led1_prev = led1;
      toggles   = 0;
      drift     = 0;
      repeat (10) begin
         @(posedge clk);
         #1;
         if (led1 !== led1_prev)
            toggles++;
         led1_prev = led1;
         if ({led3, led2} !== 2'b10)
            drift++;
      end
      check_value(32'(toggles > 0), 32'd1, "led1 blinks");
      check_value(32'(drift), 32'd0, "led2 and led3 hold their LED_OUT bits");

      bus_write(UART_DIV_ADDR, 32'(UART_DIV), 4'hF);
      byte_a = 8'($random(seed));
      fork
         receive_uart_byte(UART_DIV, rx_byte, framed);
         begin
            bus_write(UART_DATA_ADDR, 32'(byte_a), 4'hF);
            bus_read(UART_STATUS_ADDR, status_a);
         end
      join
      check_value(status_a, 32'h1, "status shows busy during a frame");
      check_value(32'(framed), 32'd1, "start and stop bits of the first frame");
      check_value(32'(rx_byte), 32'(byte_a), "first uart byte");
      wait_uart_idle();

      byte_b = 8'($random(seed));
      byte_c = 8'($random(seed));
      fork
         receive_uart_byte(UART_DIV, rx_byte, framed);
         begin
            bus_write(UART_DATA_ADDR, 32'(byte_b), 4'hF);
            bus_write(UART_DATA_ADDR, 32'(byte_c), 4'hF);
            bus_read(UART_STATUS_ADDR, status_a);
            bus_read(UART_STATUS_ADDR, status_b);
         end
      join
      check_value(status_a, 32'h3, "status shows overrun after a write while busy");
      check_value(status_b, 32'h1, "overrun cleared by the status read");
      check_value(32'(framed), 32'd1, "start and stop bits of the second frame");
      check_value(32'(rx_byte), 32'(byte_b), "uart byte sent before the overrun");

      // the dropped byte must never reach the line
      low_count = 0;
      repeat (60) begin
         @(posedge clk);
         #1;
         if (uart_tx !== 1'b1)
            low_count++;
      end
      check_value(32'(low_count), 32'd0, "uart line idle after the dropped byte");

      report_and_finish();
   end

endmodule

`default_nettype wire
